// ==== common/posit_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes for posit<32,3> only
// Derived widths assume es = 3 and a 32-bit word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef POSIT_CFG_SVH
`define POSIT_CFG_SVH

// Word and exponent field
`define POSIT_NBITS 32
`define POSIT_ES 3

// Longest stored fraction: word minus sign, two regime bits and exponent
`define POSIT_FBITS (`POSIT_NBITS - `POSIT_ES - 3)

// Signed scale of the product, twice the maxpos scale plus sign
`define POSIT_SBITS 10

// Fraction product with both hidden bits
`define POSIT_MBITS (2 * (`POSIT_FBITS + 1))

// Scale of maxpos, (nbits - 2) * 2^es
`define POSIT_MAXK 240

`endif

// ==== common/posit_word_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// External posit word and its special encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

package posit_word_pkg;

    // One word seen as raw bits or as sign plus magnitude
    typedef union packed {
        logic [`POSIT_NBITS-1:0] bits;      // Raw encoding
        struct packed {
            logic                    sign;  // Top bit
            logic [`POSIT_NBITS-2:0] mag;   // Two's complement for negative words
        } sm;
    } posit_word_u;

    // Exact zero
    localparam posit_word_u POSIT_ZERO = posit_word_u'('0);

    // Not a real, sign bit alone
    localparam posit_word_u POSIT_NAR =
        posit_word_u'({1'b1, {(`POSIT_NBITS - 1){1'b0}}});

    // Magnitudes of the largest and smallest positive posits
    localparam logic [`POSIT_NBITS-2:0] POSIT_MAXPOS_MAG = '1;
    localparam logic [`POSIT_NBITS-2:0] POSIT_MINPOS_MAG = {{(`POSIT_NBITS - 2){1'b0}}, 1'b1};

endpackage

// ==== common/posit_value_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded value types between pipeline stages
// Fractions never carry the hidden bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

package posit_value_pkg;

    // Regime times 2^es plus exponent
    typedef logic signed [`POSIT_SBITS-1:0] scale_t;

    // Operand fraction, left aligned, zero filled at the bottom
    typedef logic [`POSIT_FBITS-1:0] frac_t;

    // Normalized product fraction
    // Low one or two bits are always zero after the radix shift
    typedef logic [`POSIT_MBITS-1:0] prod_frac_t;

endpackage

// ==== hdl/lead_zero_count.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Count equals WIDTH for an all-zero vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

module lead_zero_count #(
    parameter int WIDTH = 31
) (
    input  logic [WIDTH-1:0]       vec,
    output logic [$clog2(WIDTH):0] count,
    output logic                   all_zero
);

    localparam int CW = $clog2(WIDTH) + 1;  // Room for the value WIDTH itself

    // Priority encoder
    // The scan runs upward so the highest set bit is written last
    always_comb
    begin
        count = CW'(WIDTH);
        for (int i = 0; i < WIDTH; i++)
        begin
            if (vec[i])
            begin
                count = CW'(WIDTH - 1 - i);  // Zeros above bit i
            end
        end
    end

    assign all_zero = ~|vec;  // Run fills the whole vector

endmodule

// ==== hdl/posit_extract.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational decode
// scale and frac are meaningless when zero or nar is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

module posit_extract (
    input  posit_word_pkg::posit_word_u word,
    output logic                        sign,
    output logic                        zero,
    output logic                        nar,
    output posit_value_pkg::scale_t     scale,
    output posit_value_pkg::frac_t      frac
);

    localparam int MW = `POSIT_NBITS - 1;  // Magnitude width
    localparam int CW = $clog2(MW) + 1;    // Run length width
    localparam int KW = `POSIT_SBITS - `POSIT_ES;  // Regime bits kept in scale

    logic [MW-1:0]           mag_abs;      // Absolute magnitude
    logic                    regime_bit;   // First regime bit
    logic [MW-1:0]           run_vec;      // Regime run as leading zeros
    logic [CW-1:0]           run_len;
    logic                    run_full;     // Regime runs to the last bit
    posit_value_pkg::scale_t k;            // Regime value
    logic [MW-1:0]           rest;         // Exponent and fraction, left aligned
    logic [`POSIT_ES-1:0]    exp_bits;

    // Specials from the two views of the word
    assign sign = word.sm.sign;
    assign zero = ~word.sm.sign & ~|word.sm.mag;
    assign nar  =  word.sm.sign & ~|word.sm.mag;

    // Negative posits are stored as the two's complement of the whole word
    assign mag_abs    = word.sm.sign ? -word.sm.mag : word.sm.mag;
    assign regime_bit = mag_abs[MW-1];
    assign run_vec    = regime_bit ? ~mag_abs : mag_abs;  // Ones become zeros

    lead_zero_count #(
        .WIDTH(MW)
    ) u_run_count (
        .vec      (run_vec),
        .count    (run_len),
        .all_zero (run_full)
    );

    // Run of m ones gives k = m - 1, run of m zeros gives k = -m
    assign k = regime_bit ? posit_value_pkg::scale_t'(run_len) - 1
                          : -posit_value_pkg::scale_t'(run_len);

    // Drop the run and its terminating bit
    // A full run leaves nothing behind
    assign rest = run_full ? '0 : mag_abs << (run_len + 1);

    assign exp_bits = rest[MW-1 -: `POSIT_ES];  // Truncated exponent bits read as zero
    assign frac     = rest[MW-1-`POSIT_ES -: `POSIT_FBITS];

    // k * 2^es + exponent, low bits of k are enough for |k| <= 31
    assign scale = {k[KW-1:0], exp_bits};

endmodule

// ==== posit_mult/posit_frac_mult.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 of the multiplier, one cycle from decode to product
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

module posit_frac_mult (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_in,
    input  logic                        a_sign,
    input  logic                        a_zero,
    input  logic                        a_nar,
    input  posit_value_pkg::scale_t     a_scale,
    input  posit_value_pkg::frac_t      a_frac,
    input  logic                        b_sign,
    input  logic                        b_zero,
    input  logic                        b_nar,
    input  posit_value_pkg::scale_t     b_scale,
    input  posit_value_pkg::frac_t      b_frac,
    output logic                        start_out,
    output logic                        p_sign,
    output logic                        p_zero,
    output logic                        p_nar,
    output posit_value_pkg::scale_t     p_scale,
    output posit_value_pkg::prod_frac_t p_frac
);

    logic                       a_sign_q, a_zero_q, a_nar_q;
    logic                       b_sign_q, b_zero_q, b_nar_q;
    posit_value_pkg::scale_t    a_scale_q, b_scale_q;
    posit_value_pkg::frac_t     a_frac_q, b_frac_q;
    logic [`POSIT_FBITS:0]      a_hid, b_hid;  // Fractions with hidden bit
    logic [`POSIT_MBITS-1:0]    prod;          // Value in [1, 4) with two integer bits
    posit_value_pkg::scale_t    scale_sum;

    always_ff @(posedge clk)
    begin
        if (rst)
            start_out <= 1'b0;
        else
            start_out <= start_in;
    end

    // Operand registers
    always_ff @(posedge clk)
    begin
        a_sign_q  <= a_sign;
        a_zero_q  <= a_zero;
        a_nar_q   <= a_nar;
        a_scale_q <= a_scale;
        a_frac_q  <= a_frac;
        b_sign_q  <= b_sign;
        b_zero_q  <= b_zero;
        b_nar_q   <= b_nar;
        b_scale_q <= b_scale;
        b_frac_q  <= b_frac;
    end

    assign a_hid = {1'b1, a_frac_q};
    assign b_hid = {1'b1, b_frac_q};
    assign prod  = a_hid * b_hid;  // Full width unsigned product

    assign scale_sum = a_scale_q + b_scale_q;

    // Product of 2 or more moves the radix point one place up
    assign p_scale = scale_sum + posit_value_pkg::scale_t'(prod[`POSIT_MBITS-1]);
    assign p_frac  = prod[`POSIT_MBITS-1] ? prod << 1 : prod << 2;  // Hidden bit shifted out

    assign p_sign = a_sign_q ^ b_sign_q;
    assign p_zero = a_zero_q | b_zero_q;
    assign p_nar  = a_nar_q | b_nar_q;  // NaR wins over zero downstream

endmodule

// ==== posit_mult/posit_round_encode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stages 2 and 3, outputs are combinational from stage 3
// Rounding is nearest even on the encoded bit string
// Results saturate at maxpos and minpos
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

module posit_round_encode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_in,
    input  logic                        p_sign,
    input  logic                        p_zero,
    input  logic                        p_nar,
    input  posit_value_pkg::scale_t     p_scale,
    input  posit_value_pkg::prod_frac_t p_frac,
    output posit_word_pkg::posit_word_u result,
    output logic                        inf,
    output logic                        zero,
    output logic                        done
);

    localparam int MW = `POSIT_NBITS - 1;           // Magnitude width
    localparam int TW = `POSIT_ES + `POSIT_MBITS;   // Exponent plus product fraction
    localparam int SW = $clog2(`POSIT_NBITS) + 1;   // Regime shift width
    localparam int WW = 2 * MW;                     // Regime fill, terminator and tail

    // Stage 2
    logic                        s2_start;
    logic                        s2_sign, s2_zero, s2_nar;
    posit_value_pkg::scale_t     s2_scale;
    posit_value_pkg::prod_frac_t s2_frac;
    logic                        s2_neg;           // Negative regime
    posit_value_pkg::scale_t     s2_k;
    logic [SW-1:0]               s2_shift;         // Regime length without terminator
    logic [SW-1:0]               s2_keep;          // Tail bits that fit in the word
    logic [TW-1:0]               s2_tail;
    logic [TW-1:0]               s2_leftover;      // Tail bits cut off, left aligned
    logic [WW-1:0]               s2_string;
    logic                        s2_guard, s2_sticky;

    // Stage 3
    logic                        s3_start;
    logic                        s3_sign, s3_zero, s3_nar;
    posit_value_pkg::scale_t     s3_scale;
    logic [WW-1:0]               s3_string;
    logic [SW-1:0]               s3_shift;
    logic                        s3_guard, s3_sticky;
    logic [WW-1:0]               s3_shifted;
    logic [MW-1:0]               s3_mag;
    logic                        s3_round_up;
    logic [MW-1:0]               s3_mag_rnd;
    logic                        s3_clamp_hi, s3_clamp_lo;
    logic [MW-1:0]               s3_mag_final;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s2_start <= 1'b0;
            s3_start <= 1'b0;
        end
        else
        begin
            s2_start <= start_in;
            s3_start <= s2_start;
        end
    end

    always_ff @(posedge clk)
    begin
        s2_sign  <= p_sign;
        s2_zero  <= p_zero;
        s2_nar   <= p_nar;
        s2_scale <= p_scale;
        s2_frac  <= p_frac;
    end

    assign s2_neg = s2_scale[`POSIT_SBITS-1];
    assign s2_k   = s2_scale >>> `POSIT_ES;  // Floor division by 2^es

    // k + 1 ones for k >= 0, -k zeros otherwise
    // Out of range scales give garbage here and are clamped in stage 3
    assign s2_shift = s2_neg ? SW'(-s2_k) : SW'(s2_k + 1);
    assign s2_keep  = SW'(MW - 1) - s2_shift;

    assign s2_tail = {s2_scale[`POSIT_ES-1:0], s2_frac};  // Exponent is scale mod 2^es

    // Guard is the first dropped bit, sticky the or of all below it
    assign s2_leftover = s2_tail << s2_keep;
    assign s2_guard    = s2_leftover[TW-1];
    assign s2_sticky   = |s2_leftover[TW-2:0];

    // Regime fill, terminating bit, then as much tail as can ever survive
    assign s2_string = {{MW{~s2_neg}}, s2_neg, s2_tail[TW-1 -: MW-1]};

    always_ff @(posedge clk)
    begin
        s3_sign   <= s2_sign;
        s3_zero   <= s2_zero;
        s3_nar    <= s2_nar;
        s3_scale  <= s2_scale;
        s3_string <= s2_string;
        s3_shift  <= s2_shift;
        s3_guard  <= s2_guard;
        s3_sticky <= s2_sticky;
    end

    assign s3_shifted = s3_string >> s3_shift;  // Fill bits above come in as regime
    assign s3_mag     = s3_shifted[MW-1:0];

    // Up on more than half, ties go to the even string
    assign s3_round_up = s3_guard & (s3_mag[0] | s3_sticky);
    assign s3_mag_rnd  = s3_mag + MW'(s3_round_up);

    // Regime dominates past maxpos scale
    assign s3_clamp_hi = s3_scale > `POSIT_MAXK;
    assign s3_clamp_lo = s3_scale < -`POSIT_MAXK;

    assign s3_mag_final = s3_clamp_hi ? posit_word_pkg::POSIT_MAXPOS_MAG :
                          s3_clamp_lo ? posit_word_pkg::POSIT_MINPOS_MAG :
                                        s3_mag_rnd;

    always_comb
    begin
        if (s3_nar)
            result = posit_word_pkg::POSIT_NAR;
        else if (s3_zero)
            result = posit_word_pkg::POSIT_ZERO;
        else
        begin
            result.sm.sign = s3_sign;
            result.sm.mag  = s3_sign ? -s3_mag_final : s3_mag_final;  // Negate whole word
        end
    end

    assign inf  = s3_nar;
    assign zero = s3_zero & ~s3_nar;  // NaR times zero stays NaR
    assign done = s3_start;

endmodule

// ==== posit_mult/posit_mult.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posit<32,3> multiplier, four register stages
// One product per clock, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

module posit_mult (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  posit_word_pkg::posit_word_u in1,
    input  posit_word_pkg::posit_word_u in2,
    output posit_word_pkg::posit_word_u result,
    output logic                        inf,
    output logic                        zero,
    output logic                        done
);

    posit_word_pkg::posit_word_u in1_q, in2_q;  // Stage 0 operands
    logic                        start_q;
    logic                        a_sign, a_zero, a_nar;
    logic                        b_sign, b_zero, b_nar;
    posit_value_pkg::scale_t     a_scale, b_scale;
    posit_value_pkg::frac_t      a_frac, b_frac;
    logic                        p_start;
    logic                        p_sign, p_zero, p_nar;
    posit_value_pkg::scale_t     p_scale;
    posit_value_pkg::prod_frac_t p_frac;

    always_ff @(posedge clk)
    begin
        if (rst)
            start_q <= 1'b0;
        else
            start_q <= start;
    end

    // Operands are sampled every cycle
    always_ff @(posedge clk)
    begin
        in1_q <= in1;
        in2_q <= in2;
    end

    posit_extract u_extract_a (
        .word  (in1_q),
        .sign  (a_sign),
        .zero  (a_zero),
        .nar   (a_nar),
        .scale (a_scale),
        .frac  (a_frac)
    );

    posit_extract u_extract_b (
        .word  (in2_q),
        .sign  (b_sign),
        .zero  (b_zero),
        .nar   (b_nar),
        .scale (b_scale),
        .frac  (b_frac)
    );

    // Stage 1
    posit_frac_mult u_frac_mult (
        .clk       (clk),
        .rst       (rst),
        .start_in  (start_q),
        .a_sign    (a_sign),
        .a_zero    (a_zero),
        .a_nar     (a_nar),
        .a_scale   (a_scale),
        .a_frac    (a_frac),
        .b_sign    (b_sign),
        .b_zero    (b_zero),
        .b_nar     (b_nar),
        .b_scale   (b_scale),
        .b_frac    (b_frac),
        .start_out (p_start),
        .p_sign    (p_sign),
        .p_zero    (p_zero),
        .p_nar     (p_nar),
        .p_scale   (p_scale),
        .p_frac    (p_frac)
    );

    // Stages 2 and 3
    posit_round_encode u_round_encode (
        .clk      (clk),
        .rst      (rst),
        .start_in (p_start),
        .p_sign   (p_sign),
        .p_zero   (p_zero),
        .p_nar    (p_nar),
        .p_scale  (p_scale),
        .p_frac   (p_frac),
        .result   (result),
        .inf      (inf),
        .zero     (zero),
        .done     (done)
    );

endmodule

// ==== dv/posit_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference posit<32,3> multiply for the testbench
// Exact product rounded to nearest even on the bit string
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

// Scale and significand with the hidden bit at the top
task automatic decode_posit(input logic [31:0] w, output int scale, output logic [26:0] sig);
    logic [31:0] a;
    logic        first;
    int          run;
    int          pos;
    int          e;
    int          n;
    a     = w[31] ? -w : w;  // Negative words are two's complement
    first = a[30];
    run   = 0;
    while (run < 31 && a[30 - run] == first)
        run++;
    pos = 29 - run;          // Skip the terminating bit
    e   = 0;
    for (n = 0; n < 3; n++)
    begin
        e = e * 2 + ((pos >= 0) ? int'(a[pos]) : 0);  // Bits past the end count as zero
        pos--;
    end
    sig = 27'h400_0000;
    for (n = 25; n >= 0; n--)
    begin
        if (pos >= 0)
            sig[n] = a[pos];
        pos--;
    end
    scale = (first ? run - 1 : -run) * 8 + e;
endtask

task automatic model_product(input logic [31:0] x, input logic [31:0] y, output logic [31:0] r);
    int           sx, sy, sc;
    int           k, e, n, i;
    logic [26:0]  fx, fy;
    logic [53:0]  p;
    logic [127:0] str;       // Regime, exponent and fraction, left aligned
    logic [30:0]  mag;
    logic         guard, sticky;
    if (x == 32'h8000_0000 || y == 32'h8000_0000)
        r = 32'h8000_0000;
    else if (x == 32'h0 || y == 32'h0)
        r = 32'h0;
    else
    begin
        decode_posit(x, sx, fx);
        decode_posit(y, sy, fy);
        p  = fx * fy;
        sc = sx + sy;
        if (p[53])
            sc = sc + 1;
        else
            p = p << 1;      // Leading one now at bit 53
        if (sc > `POSIT_MAXK)
            mag = '1;        // maxpos
        else if (sc < -`POSIT_MAXK)
            mag = 31'd1;     // minpos
        else
        begin
            k   = (sc >= 0) ? sc / 8 : -((7 - sc) / 8);  // Floor
            e   = sc - 8 * k;
            str = '0;
            n   = 127;
            for (i = 0; i < ((k >= 0) ? k + 1 : -k); i++)
            begin
                str[n] = (k >= 0);
                n--;
            end
            str[n] = (k < 0);
            n--;
            for (i = 2; i >= 0; i--)
            begin
                str[n] = e[i];
                n--;
            end
            for (i = 52; i >= 0; i--)
            begin
                str[n] = p[i];
                n--;
            end
            mag    = str[127:97];
            guard  = str[96];
            sticky = |str[95:0];
            if (guard && (mag[0] || sticky))
                mag = mag + 31'd1;
        end
        r = (x[31] ^ y[31]) ? -{1'b0, mag} : {1'b0, mag};
    end
endtask

`endif

// ==== dv/posit_mult_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed table then seeded random products
// Stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "posit_cfg.svh"

module posit_mult_tb;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 5;
    localparam int TABLE_LEN    = 14;
    localparam int NUM_RANDOM   = 2000;
    localparam int GAP_EVERY    = 16;   // Idle cycle after this many random starts
    localparam int LATENCY      = 4;
    localparam int RUN_CYCLES   =
        TABLE_LEN + NUM_RANDOM + NUM_RANDOM / GAP_EVERY + RESET_CYCLES + 20;
    localparam logic [31:0] NAR_WORD = 32'h8000_0000;

    logic                        clk;
    logic                        rst;
    logic                        start;
    posit_word_pkg::posit_word_u in1, in2, result;
    logic                        inf, zero, done;
    int                          cycles = 0;
    logic [31:0]                 exp_q[$];    // Expected words in issue order
    int                          issue_q[$];  // Edge just before each start rises

    // Operand a, operand b, expected word
    logic [95:0] vec_table [TABLE_LEN] = '{
        {32'h4000_0000, 32'h4000_0000, 32'h4000_0000},  // 1 x 1
        {32'h4400_0000, 32'h3C00_0000, 32'h4000_0000},  // 2 x 0.5
        {32'hC000_0000, 32'h4800_0000, 32'hB800_0000},  // -1 x 4
        {32'h4200_0000, 32'h4200_0000, 32'h4480_0000},  // 1.5 x 1.5
        {32'hC000_0000, 32'hC000_0000, 32'h4000_0000},  // -1 x -1
        {32'h0000_0000, 32'h4200_0000, 32'h0000_0000},
        {32'h8000_0000, 32'h4000_0000, 32'h8000_0000},  // NaR x 1
        {32'h8000_0000, 32'h0000_0000, 32'h8000_0000},  // NaR x 0
        {32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h7FFF_FFFF},  // maxpos squared
        {32'h7FFF_FFFE, 32'h7FFF_FFFE, 32'h7FFF_FFFF},
        {32'h7FFF_FFFF, 32'h3C00_0000, 32'h7FFF_FFFF},  // Rounds back up to maxpos
        {32'h8000_0001, 32'h7FFF_FFFF, 32'h8000_0001},  // -maxpos
        {32'h0000_0001, 32'h0000_0001, 32'h0000_0001},  // minpos squared
        {32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF}   // -minpos
    };

    `include "posit_model.svh"

    posit_mult dut0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .in1    (in1),
        .in2    (in2),
        .result (result),
        .inf    (inf),
        .zero   (zero),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycles <= cycles + 1;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected)
            abort_run($sformatf("** Error at %0t: %s = %0h, expected %0h",
                                $time, name, got, expected));
    endtask

    // One cycle of stimulus with an expected entry only for a real start
    task automatic apply_op(input logic go, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] expected);
        @(posedge clk);
        #1;
        start = go;
        in1   = a;
        in2   = b;
        if (go)
        begin
            exp_q.push_back(expected);
            issue_q.push_back(cycles);  // done rises four edges after this one
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin : monitor
        logic [31:0] expected;
        int          issued;
        if (cycles > 0 && done !== 1'b0)
        begin
            if (exp_q.size() == 0)
                abort_run("done went high with no operation in flight");
            else
            begin
                check_value("done", done, 1'b1);
                expected = exp_q.pop_front();
                issued   = issue_q.pop_front();
                check_value("latency", cycles - issued, LATENCY);
                check_value("result", result.bits, expected);
                check_value("inf", inf, expected == NAR_WORD);
                check_value("zero", zero, expected == 32'h0);
            end
        end
    end

    initial
    begin
        #(RUN_CYCLES * PERIOD);
        abort_run("Timeout, the run took longer than the tests allow");
    end

    initial
    begin : stimulus
        integer      seed;
        logic [31:0] a, b, expected;
        int          i;
        seed  = 32'h87a6;
        rst   = 1'b1;
        start = 1'b0;
        in1   = '0;
        in2   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (i = 0; i < TABLE_LEN; i++)
            apply_op(1'b1, vec_table[i][95:64], vec_table[i][63:32], vec_table[i][31:0]);
        apply_op(1'b0, 32'h0, 32'h0, 32'h0);  // Gap before the random phase
        for (i = 0; i < NUM_RANDOM; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            model_product(a, b, expected);
            apply_op(1'b1, a, b, expected);
            if (i % GAP_EVERY == GAP_EVERY - 1)
                apply_op(1'b0, ~a, ~b, 32'h0);  // Live operands without start
        end
        apply_op(1'b0, 32'h0, 32'h0, 32'h0);
        repeat (LATENCY + 2) @(posedge clk);
        if (exp_q.size() != 0)
            abort_run("Some operations never produced done");
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+common
+incdir+dv
common/posit_word_pkg.sv
common/posit_value_pkg.sv
hdl/lead_zero_count.sv
hdl/posit_extract.sv
posit_mult/posit_frac_mult.sv
posit_mult/posit_round_encode.sv
posit_mult/posit_mult.sv
dv/posit_mult_tb.sv

// ==== Bender.yml ====
package:
  name: posit_mult

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/posit_word_pkg.sv
      - common/posit_value_pkg.sv
      - hdl/lead_zero_count.sv
      - hdl/posit_extract.sv
      - posit_mult/posit_frac_mult.sv
      - posit_mult/posit_round_encode.sv
      - posit_mult/posit_mult.sv
  - target: test
    include_dirs:
      - common
      - dv
    files:
      - dv/posit_mult_tb.sv
